// File: menu_show.f
design/menu_pkg.sv
design/char_sequencer.sv
design/score_follower.sv
design/char_glyph.sv
design/char_place.sv
design/char_palette.sv
design/menu_show.sv
bench/clock_gen.sv
bench/menu_show_chk.sv
bench/menu_show_tb.sv

// File: bench/menu_show_tb.sv
//----------------------------------------
// table-driven testbench for menu_show
// plays the character writer and the keypad, checks every descriptor
//----------------------------------------
module menu_show_tb
    import menu_pkg::*;
;

    typedef struct packed {
        scale_t    scale;
        logic      pressed;
        logic [3:0] code;
        song_id_t  song;   // expected view after the key
        note_pos_t pos;
    } step_t;

    localparam int num_steps    = 22;
    localparam int flag_timeout = 20;   // cycles

    localparam step_t step_table [num_steps] = '{
        '{scale_low,  1'b0, 4'h0, 2'd0, 4'd0},  // marker on each row
        '{scale_mid,  1'b0, 4'h0, 2'd0, 4'd0},
        '{scale_high, 1'b0, 4'h0, 2'd0, 4'd0},
        '{scale_mid,  1'b1, 4'h5, 2'd0, 4'd1},  // right note
        '{scale_mid,  1'b1, 4'h4, 2'd0, 4'd1},  // wrong note
        '{scale_low,  1'b1, 4'h3, 2'd0, 4'd2},
        '{scale_low,  1'b1, 4'h9, 2'd0, 4'd2},  // not a note key
        '{scale_high, 1'b1, 4'hE, 2'd1, 4'd0},
        '{scale_high, 1'b1, 4'hE, 2'd2, 4'd0},
        '{scale_high, 1'b1, 4'h3, 2'd2, 4'd1},  // play song 2 to the end
        '{scale_high, 1'b1, 4'h6, 2'd2, 4'd2},
        '{scale_mid,  1'b1, 4'h3, 2'd2, 4'd3},
        '{scale_mid,  1'b1, 4'h5, 2'd2, 4'd4},
        '{scale_mid,  1'b1, 4'h6, 2'd2, 4'd5},
        '{scale_low,  1'b1, 4'h7, 2'd2, 4'd6},
        '{scale_low,  1'b1, 4'h1, 2'd2, 4'd7},
        '{scale_low,  1'b1, 4'h2, 2'd2, 4'd8},
        '{scale_low,  1'b1, 4'h6, 2'd2, 4'd0},  // wraps to the start
        '{scale_low,  1'b1, 4'hF, 2'd1, 4'd0},
        '{scale_low,  1'b1, 4'hF, 2'd0, 4'd0},
        '{scale_mid,  1'b1, 4'hF, 2'd3, 4'd0},  // 0 back to 3
        '{scale_mid,  1'b1, 4'h2, 2'd3, 4'd1}
    };

    logic      sys_clk;
    logic      sys_rst_n;
    logic      init_done;
    logic      show_char_done;
    key_evt_t  key;
    scale_t    scale;
    logic      show_char_flag;
    lcd_char_t char_out;

    int errors;
    int step_errors;
    int checks;
    int cur_idx;   // index the writer expects next

    clock_gen u_clock (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    menu_show dut (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .init_done      (init_done),
        .show_char_done (show_char_done),
        .key            (key),
        .scale          (scale),
        .show_char_flag (show_char_flag),
        .char_out       (char_out)
    );

    bind menu_show menu_show_chk u_chk (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .init_done      (init_done),
        .show_char_flag (show_char_flag),
        .char_idx       (char_idx),
        .char_out       (char_out)
    );

    //----------------------------------------
    // expected screen content
    //----------------------------------------
    function automatic logic [7:0] expect_glyph(input int idx, input int sc,
                                                input int song, input int pos);
        string      title   = "KeyBoard";
        string      labels  = "LOWMIDHIG";
        string      sample  = "SAMPLE:";
        string      letters = "LMH";
        int         r;
        int         c;
        int         n;
        logic [7:0] ch;
        ch = " ";
        r  = (idx - grid_base) / row_len;
        c  = (idx - grid_base) % row_len;
        if (idx < title_len)
            ch = title[idx];
        else if (idx < sample_base) begin
            if (c < 3)
                ch = labels[3 * r + c];
            else if (c == 3)
                ch = ">";
            else if (c == 19)
                ch = (r == sc) ? "<" : " ";
            else if (c >= 5 && c <= 17 && c % 2 == 1)
                ch = 8'd48 + 8'((c - 3) / 2);  // digits 1 to 7
        end else if (idx < 75)
            ch = sample[idx - sample_base];
        else if (idx == 76)
            ch = ">";
        else if (idx == 77)
            ch = letters[sc];
        else if (idx == 78)
            ch = "<";
        else if (idx >= 80 && idx < 88)
            ch = song_name[song][8 * (87 - idx) +: 8];  // first letter in the top byte
        else if (idx == 88)
            ch = "-";
        else if (idx == 89)
            ch = ">";
        else if (idx >= 91 && idx % 2 == 1) begin
            n = pos + (idx - 91) / 2;
            if (n < song_len[song])
                ch = 8'd48 + 8'(song_notes[song][n]);
        end
        return ch - glyph_offset;
    endfunction

    function automatic logic [17:0] expect_place(input int idx);
        int rel;
        int y0;
        if (idx < title_len)
            return {9'(48 + 8 * idx), 9'd0};
        rel = (idx < sample_base) ? idx - grid_base : idx - sample_base;
        y0  = (idx < sample_base) ? 32 : 96;
        return {9'(1 + 8 * (rel % row_len)), 9'(y0 + 16 * (rel / row_len))};
    endfunction

    // {bg, fg}
    function automatic logic [31:0] expect_colors(input int idx, input int sc,
                                                  input key_evt_t k);
        int r;
        int c;
        r = (idx - grid_base) / row_len;
        c = (idx - grid_base) % row_len;
        if (idx < title_len)
            return {col_text_bg, col_black};
        if (idx < sample_base) begin
            if (c < 3)
                return {col_label_bg, col_white};
            if (k.pressed && k.code >= 1 && k.code <= 7 && r == sc && c == 3 + 2 * k.code)
                return {col_press_bg, col_white};
            return {col_text_bg, col_black};
        end
        if (idx <= 74)
            return {col_sample_bg, col_white};
        if (idx >= 76 && idx <= 78)
            return {col_label_bg, col_white};
        if (idx >= 80 && idx <= 87)
            return {col_name_bg, col_black};
        if (idx == 91)
            return {col_beat_bg, col_label_bg};
        return {col_menu_bg, col_black};
    endfunction

    //----------------------------------------
    // checks and writer emulation
    //----------------------------------------
    task automatic compare_field(input string what, input int idx,
                                 input logic [57:0] got, input logic [57:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            step_errors++;
            $display("ERR t=%0t idx %0d %s got %0h expected %0h", $time, idx, what, got, exp);
        end
    endtask

    task automatic check_char(input int idx, input step_t st);
        key_evt_t    k;
        logic [17:0] xy;
        logic [31:0] cols;
        k    = '{pressed: st.pressed, code: st.code};
        xy   = expect_place(idx);
        cols = expect_colors(idx, st.scale, k);
        compare_field("glyph", idx, char_out.glyph,
                      expect_glyph(idx, st.scale, st.song, st.pos));
        compare_field("x", idx, char_out.x, xy[17:9]);
        compare_field("y", idx, char_out.y, xy[8:0]);
        compare_field("bg", idx, char_out.bg, cols[31:16]);
        compare_field("fg", idx, char_out.fg, cols[15:0]);
    endtask

    // init_done low: no pulse and a blank descriptor
    task automatic watch_idle_output(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            compare_field("idle flag", cur_idx, show_char_flag, 1'b0);
            compare_field("idle char_out", cur_idx, char_out,
                          {8'd0, 9'd0, 9'd0, col_white, col_black});
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    // answer one start pulse and check the next descriptor
    task automatic draw_char(input step_t st);
        int t;
        t = 0;
        while (!show_char_flag && t < flag_timeout) begin
            @(negedge sys_clk);
            t++;
        end
        if (!show_char_flag)
            stop_on_timeout("no show_char_flag pulse from the DUT");
        show_char_done = 1'b1;
        @(negedge sys_clk);
        show_char_done = 1'b0;
        @(negedge sys_clk);             // index moved, then descriptor registered
        cur_idx = (cur_idx + 1) % char_count;
        check_char(cur_idx, st);
    endtask

    //----------------------------------------
    // main sequence
    //----------------------------------------
    initial begin
        int t;
        init_done      = 1'b0;
        show_char_done = 1'b0;
        key            = '0;
        scale          = scale_low;
        errors         = 0;
        step_errors    = 0;
        checks         = 0;
        cur_idx        = 0;

        t = 0;
        while (sys_rst_n !== 1'b1 && t < 50) begin
            @(negedge sys_clk);
            t++;
        end
        if (sys_rst_n !== 1'b1)
            stop_on_timeout("reset never released");

        // idle output before the LCD is ready
        watch_idle_output(3);

        init_done = 1'b1;
        t = 0;
        do begin
            @(negedge sys_clk);
            t++;
        end while (!show_char_flag && t < flag_timeout);
        compare_field("first flag delay", 0, t, 3);
        t = 0;
        do begin
            @(negedge sys_clk);
            t++;
        end while (!show_char_flag && t < flag_timeout);
        compare_field("flag period", 0, t, 4);
        check_char(0, step_table[0]);
        $display("startup: %0d errors", step_errors);

        for (int s = 0; s < num_steps; s++) begin
            step_errors = 0;
            scale       = step_table[s].scale;
            key         = '{pressed: step_table[s].pressed, code: step_table[s].code};
            if (step_table[s].pressed)
                repeat (4) @(negedge sys_clk);  // follower settles
            repeat (char_count / 2) draw_char(step_table[s]);
            init_done = 1'b0;                   // LCD busy mid screen, state holds
            watch_idle_output(3);
            init_done = 1'b1;
            repeat (char_count - char_count / 2) draw_char(step_table[s]);
            compare_field("index after sweep", cur_idx, dut.char_idx, 7'd0);
            key = '0;
            repeat (2) @(negedge sys_clk);      // back to idle
            $display("step %0d scale %0d key %h song %0d pos %0d: %0d errors",
                     s, step_table[s].scale, step_table[s].code,
                     step_table[s].song, step_table[s].pos, step_errors);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: bench/menu_show_chk.sv
//----------------------------------------
// protocol and range assertions for menu_show
// attached to the top level from the testbench
//----------------------------------------
module menu_show_chk
    import menu_pkg::*;
(
    input logic      sys_clk,
    input logic      sys_rst_n,
    input logic      init_done,
    input logic      show_char_flag,
    input logic [6:0] char_idx,
    input lcd_char_t char_out
);

    localparam lcd_char_t idle_char = '{glyph: 8'd0, x: 9'd0, y: 9'd0,
                                        bg: col_white, fg: col_black};

    flag_one_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        show_char_flag |=> !show_char_flag)
        else $error("show_char_flag high for two cycles");

    idx_in_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        char_idx < char_count)
        else $error("char_idx %0d out of range", char_idx);

    // output drops to the blank descriptor one edge after init_done falls
    idle_output: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !init_done |=> char_out == idle_char)
        else $error("char_out not at its idle value while init_done is low");

endmodule

// File: bench/clock_gen.sv
//----------------------------------------
// testbench clock and reset
// 10 unit period, reset low for the first 5 cycles
//----------------------------------------
module clock_gen (
    output logic sys_clk,
    output logic sys_rst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;  // half period
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (5) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;  // released between edges
    end

endmodule

// File: design/menu_show.sv
//----------------------------------------
// keyboard menu screen, top level
// streams one character descriptor per show_char_done
//----------------------------------------
module menu_show
    import menu_pkg::*;
(
    input  logic      sys_clk,
    input  logic      sys_rst_n,
    input  logic      init_done,
    input  logic      show_char_done,
    input  key_evt_t  key,
    input  scale_t    scale,
    output logic      show_char_flag,
    output lcd_char_t char_out
);

    logic [6:0]  char_idx;
    score_view_t view;
    logic [7:0]  glyph;
    logic [8:0]  x;
    logic [8:0]  y;
    logic [15:0] bg;
    logic [15:0] fg;

    char_sequencer u_sequencer (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .init_done      (init_done),
        .show_char_done (show_char_done),
        .show_char_flag (show_char_flag),
        .char_idx       (char_idx)
    );

    score_follower u_follower (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .init_done (init_done),
        .key       (key),
        .view      (view)
    );

    char_glyph u_glyph (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .init_done (init_done),
        .char_idx  (char_idx),
        .scale     (scale),
        .view      (view),
        .glyph     (glyph)
    );

    char_place u_place (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .init_done (init_done),
        .char_idx  (char_idx),
        .x         (x),
        .y         (y)
    );

    char_palette u_palette (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .init_done (init_done),
        .char_idx  (char_idx),
        .scale     (scale),
        .key       (key),
        .bg        (bg),
        .fg        (fg)
    );

    assign char_out = '{glyph: glyph, x: x, y: y, bg: bg, fg: fg};

endmodule

// File: design/char_palette.sv
//----------------------------------------
// background and text colors of the current character
// the held note key is highlighted on the active scale row
//----------------------------------------
module char_palette
    import menu_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        init_done,
    input  logic [6:0]  char_idx,
    input  scale_t      scale,
    input  key_evt_t    key,
    output logic [15:0] bg,
    output logic [15:0] fg
);

    logic [6:0]  rel;
    logic [4:0]  col;
    logic [1:0]  row;
    logic        key_hit;  // digit of the held key
    logic [15:0] bg_next;
    logic [15:0] fg_next;

    always_comb begin
        rel     = char_idx - 7'(grid_base);
        col     = 5'(rel % row_len);
        row     = 2'(rel / row_len);
        key_hit = key.pressed && key.code >= 4'd1 && key.code <= 4'd7 &&
                  row == scale && col == ({key.code, 1'b0} + 5'd3);
        bg_next = col_menu_bg;
        fg_next = col_black;

        if (char_idx < title_len) begin
            bg_next = col_text_bg;
        end else if (char_idx < sample_base) begin
            if (col < 5'd3) begin       // row label
                bg_next = col_label_bg;
                fg_next = col_white;
            end else if (key_hit) begin
                bg_next = col_press_bg;
                fg_next = col_white;
            end else begin
                bg_next = col_text_bg;
            end
        end else if (char_idx < sample_base + label_len) begin
            bg_next = col_sample_bg;
            fg_next = col_white;
        end else if (char_idx >= scale_open_idx && char_idx <= scale_close_idx) begin
            bg_next = col_label_bg;
            fg_next = col_white;
        end else if (char_idx >= name_base && char_idx < name_base + name_len) begin
            bg_next = col_name_bg;
        end else if (char_idx == notes_base) begin
            bg_next = col_beat_bg;      // note to play next
            fg_next = col_label_bg;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bg <= col_white;
            fg <= col_black;
        end else if (init_done) begin
            bg <= bg_next;
            fg <= fg_next;
        end else begin
            bg <= col_white;
            fg <= col_black;
        end
    end

endmodule

// File: design/char_place.sv
//----------------------------------------
// screen position of the current character
//----------------------------------------
module char_place
    import menu_pkg::*;
(
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       init_done,
    input  logic [6:0] char_idx,
    output logic [8:0] x,
    output logic [8:0] y
);

    logic [6:0] base;    // first char of the text block
    logic [6:0] rel;
    logic [4:0] col;
    logic [1:0] row;
    logic [8:0] x_next;
    logic [8:0] y_next;

    always_comb begin
        base = (char_idx < sample_base) ? 7'(grid_base) : 7'(sample_base);
        rel  = char_idx - base;
        col  = 5'(rel % row_len);
        row  = 2'(rel / row_len);
        if (char_idx < title_len) begin
            x_next = 9'(title_x0 + char_w * char_idx);
            y_next = 9'd0;
        end else begin
            x_next = 9'(margin_x + char_w * col);
            y_next = 9'(((char_idx < sample_base) ? grid_y0 : sample_y0) + char_h * row);
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            x <= 9'd0;
            y <= 9'd0;
        end else if (init_done) begin
            x <= x_next;
            y <= y_next;
        end else begin
            x <= 9'd0;
            y <= 9'd0;
        end
    end

endmodule

// File: design/char_glyph.sv
//----------------------------------------
// font code of the current character
// registered, zero while the LCD is not initialised
//----------------------------------------
module char_glyph
    import menu_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        init_done,
    input  logic [6:0]  char_idx,
    input  scale_t      scale,
    input  score_view_t view,
    output logic [7:0]  glyph
);

    logic [6:0] rel;         // offset inside the note grid
    logic [4:0] col;
    logic [1:0] row;
    logic [3:0] ahead;       // notes past the current one
    logic [4:0] note_num;    // song position shown here
    logic [7:0] glyph_next;

    always_comb begin
        rel        = char_idx - 7'(grid_base);
        col        = 5'(rel % row_len);
        row        = 2'(rel / row_len);
        ahead      = 4'((char_idx - 7'(notes_base)) >> 1);
        note_num   = {1'b0, view.pos} + {1'b0, ahead};
        glyph_next = glyph_space;

        if (char_idx < title_len) begin
            glyph_next = to_glyph(title_text[8 * (title_len - 1 - char_idx) +: 8]);
        end else if (char_idx < sample_base) begin
            // note rows: "LOW> 1 2 3 4 5 6 7 <"
            if (col < 5'd3)
                glyph_next = to_glyph(row_labels[8 * (8 - 3 * row - col) +: 8]);
            else if (col == 5'd3)
                glyph_next = glyph_gt;
            else if (col == 5'(row_len - 1))
                glyph_next = (row == scale) ? glyph_lt : glyph_space;  // scale marker
            else if (col[0] && col >= 5'd5)
                glyph_next = glyph_digit0 + 8'((col - 5'd3) >> 1);
        end else if (char_idx < sample_base + label_len) begin
            glyph_next = to_glyph(sample_text[8 * (sample_base + label_len - 1 - char_idx) +: 8]);
        end else if (char_idx == scale_open_idx) begin
            glyph_next = glyph_gt;
        end else if (char_idx == scale_letter_idx) begin
            case (scale)
                scale_low:  glyph_next = to_glyph("L");
                scale_mid:  glyph_next = to_glyph("M");
                scale_high: glyph_next = to_glyph("H");
                default:    glyph_next = glyph_space;
            endcase
        end else if (char_idx == scale_close_idx) begin
            glyph_next = glyph_lt;
        end else if (char_idx >= name_base && char_idx < name_base + name_len) begin
            glyph_next = to_glyph(song_name[view.song][8 * (name_base + name_len - 1 - char_idx) +: 8]);
        end else if (char_idx == arrow_base) begin
            glyph_next = glyph_dash;
        end else if (char_idx == arrow_base + 1) begin
            glyph_next = glyph_gt;
        end else if (char_idx >= notes_base && char_idx[0] && note_num < song_len[view.song]) begin
            // blank once the view runs past the song end
            glyph_next = glyph_digit0 + 8'(song_notes[view.song][note_num[3:0]]);
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            glyph <= 8'd0;
        else if (init_done)
            glyph <= glyph_next;
        else
            glyph <= 8'd0;
    end

endmodule

// File: design/score_follower.sv
//----------------------------------------
// follows the sample song on the keypad
// right note advances, E/F step through the songs
//----------------------------------------
module score_follower
    import menu_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst_n,
    input  logic        init_done,
    input  key_evt_t    key,
    output score_view_t view
);

    follow_state_t state;
    logic [2:0]    expected;   // note the player should press
    logic          last_note;  // position at end of song

    assign expected  = song_notes[view.song][view.pos];
    assign last_note = ({1'b0, view.pos} == song_len[view.song] - 5'd1);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= st_idle;
        end else if (init_done) begin
            case (state)
                st_idle: begin
                    if (key.pressed)
                        state <= st_judge;
                end
                st_judge: begin
                    if (key.code == {1'b0, expected})
                        state <= st_advance;
                    else if (key.code == key_e || key.code == key_f)
                        state <= st_select;
                    else
                        state <= st_release;  // wrong key, nothing changes
                end
                st_advance: state <= st_release;
                st_select:  state <= st_load;
                st_load:    state <= st_release;
                st_release: begin
                    if (!key.pressed)
                        state <= st_idle;
                end
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            view <= '0;
        end else if (init_done) begin
            case (state)
                st_advance: begin
                    if (last_note)
                        view.pos <= '0;
                    else
                        view.pos <= view.pos + 4'd1;
                end
                st_select: begin
                    if (key.code == key_f)
                        view.song <= view.song - 2'd1;  // 0 wraps to 3
                    else
                        view.song <= view.song + 2'd1;
                end
                st_load:   view.pos <= '0;  // new song from its start
                default:   view <= view;
            endcase
        end
    end

endmodule

// File: design/char_sequencer.sv
//----------------------------------------
// start pulse for the character writer and the
// index of the character being drawn
//----------------------------------------
module char_sequencer
    import menu_pkg::*;
(
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       init_done,
    input  logic       show_char_done,
    output logic       show_char_flag,
    output logic [6:0] char_idx
);

    logic [1:0] delay_cnt;  // phase of the 4-cycle start pulse

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            delay_cnt      <= 2'd0;
            show_char_flag <= 1'b0;
        end else if (init_done) begin
            delay_cnt      <= delay_cnt + 2'd1;
            show_char_flag <= (delay_cnt == 2'd2);  // third cycle of each period
        end else begin
            show_char_flag <= 1'b0;  // phase holds
        end
    end

    // one step per finished character
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_idx <= 7'd0;
        end else if (init_done && show_char_done) begin
            if (char_idx == 7'(char_count - 1))
                char_idx <= 7'd0;  // wrap to the title
            else
                char_idx <= char_idx + 7'd1;
        end
    end

endmodule

// File: design/menu_pkg.sv
//----------------------------------------
// constants, song table and types for the keyboard menu screen
// every design module imports this with menu_pkg::*
//----------------------------------------
package menu_pkg;

    //----------------------------------------
    // screen layout, character indices
    //----------------------------------------
    localparam int char_count       = 108;  // characters per screen
    localparam int title_len        = 8;
    localparam int row_len          = 20;   // characters per text row
    localparam int grid_base        = 8;    // first char of the LOW row
    localparam int sample_base      = 68;   // first char of the sample line
    localparam int label_len        = 7;    // "SAMPLE:"
    localparam int scale_open_idx   = 76;
    localparam int scale_letter_idx = 77;
    localparam int scale_close_idx  = 78;
    localparam int name_base        = 80;
    localparam int name_len         = 8;
    localparam int arrow_base       = 88;
    localparam int notes_base       = 91;   // next note, then every other column

    // pixel geometry, 8x16 font
    localparam int title_x0  = 48;          // centred title
    localparam int margin_x  = 1;
    localparam int grid_y0   = 32;
    localparam int sample_y0 = 96;
    localparam int char_w    = 8;
    localparam int char_h    = 16;

    //----------------------------------------
    // glyph codes
    //----------------------------------------
    localparam logic [7:0] glyph_offset = 8'd32;  // font code = ascii - offset
    localparam logic [7:0] glyph_space  = 8'd32 - glyph_offset;
    localparam logic [7:0] glyph_lt     = 8'd60 - glyph_offset;
    localparam logic [7:0] glyph_gt     = 8'd62 - glyph_offset;
    localparam logic [7:0] glyph_dash   = 8'd45 - glyph_offset;
    localparam logic [7:0] glyph_digit0 = 8'd48 - glyph_offset;

    localparam logic [8*title_len-1:0] title_text  = "KeyBoard";
    localparam logic [71:0]            row_labels  = "LOWMIDHIG";  // 3 letters per row
    localparam logic [8*label_len-1:0] sample_text = "SAMPLE:";

    localparam logic [3:0] key_e = 4'hE;  // next song
    localparam logic [3:0] key_f = 4'hF;  // previous song

    // RGB565
    localparam logic [15:0] col_text_bg   = 16'hAF7D;
    localparam logic [15:0] col_label_bg  = 16'h815B;
    localparam logic [15:0] col_press_bg  = 16'hFA20;
    localparam logic [15:0] col_sample_bg = 16'hF810;
    localparam logic [15:0] col_name_bg   = 16'h97F9;
    localparam logic [15:0] col_beat_bg   = 16'hBFD9;
    localparam logic [15:0] col_menu_bg   = 16'hE73F;
    localparam logic [15:0] col_white     = 16'hFFFF;
    localparam logic [15:0] col_black     = 16'h0000;

    //----------------------------------------
    // sample songs
    //----------------------------------------
    localparam int num_songs    = 4;
    localparam int max_song_len = 16;

    typedef logic [1:0] song_id_t;
    typedef logic [3:0] note_pos_t;

    // unused tail entries padded with 1
    localparam logic [2:0] song_notes [num_songs][max_song_len] = '{
        '{3'd5, 3'd3, 3'd2, 3'd3, 3'd5, 3'd3, 3'd2, 3'd1,
          3'd2, 3'd1, 3'd2, 3'd2, 3'd3, 3'd5, 3'd3, 3'd6},
        '{3'd3, 3'd1, 3'd1, 3'd2, 3'd3, 3'd2, 3'd1, 3'd5,
          3'd4, 3'd6, 3'd3, 3'd5, 3'd1, 3'd1, 3'd1, 3'd1},
        '{3'd3, 3'd6, 3'd3, 3'd5, 3'd6, 3'd7, 3'd1, 3'd2,
          3'd6, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1},
        '{3'd2, 3'd2, 3'd4, 3'd5, 3'd6, 3'd6, 3'd5, 3'd4,
          3'd2, 3'd1, 3'd2, 3'd3, 3'd3, 3'd4, 3'd1, 3'd1}
    };
    localparam logic [4:0]  song_len  [num_songs] = '{5'd16, 5'd12, 5'd9, 5'd14};
    localparam logic [63:0] song_name [num_songs] = '{
        "  QHC   ", "  C418  ", "   ZH   ", "  QBY   "
    };

    //----------------------------------------
    // shared types
    //----------------------------------------
    typedef struct packed {
        logic       pressed;  // high while the key is held
        logic [3:0] code;
    } key_evt_t;

    typedef struct packed {
        song_id_t  song;
        note_pos_t pos;
    } score_view_t;

    typedef struct packed {
        logic [7:0]  glyph;
        logic [8:0]  x;
        logic [8:0]  y;
        logic [15:0] bg;
        logic [15:0] fg;
    } lcd_char_t;

    typedef enum logic [2:0] {
        st_idle, st_judge, st_advance, st_select, st_load, st_release
    } follow_state_t;

    typedef enum logic [1:0] {scale_low, scale_mid, scale_high} scale_t;

    function automatic logic [7:0] to_glyph(input logic [7:0] ascii);
        return ascii - glyph_offset;
    endfunction

endpackage
